/* bcdAdderPkg.sv */
package bcdAdderPkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Opcode field
    localparam int OP_W = 3;

    // Binary operand A or B, 0 to 255
    localparam int OPERAND_W = 8;

    // Sum and the binary value handed to conversion, 0 to 510
    localparam int SUM_W = 9;

    // One BCD digit
    localparam int DIGIT_W = 4;

    // Hundreds, tens, ones
    localparam int DISPLAY_W = 12;
    localparam int NUM_DIGITS = DISPLAY_W / DIGIT_W;

    // Largest legal digit values
    localparam int DIGIT_MAX = 9;
    localparam int HUNDREDS_MAX = 5;

    // Command to acknowledge, one register per stage
    localparam int PIPE_DEPTH = 3;

    //////////////////////////////////////////////////
    // Command opcodes
    //////////////////////////////////////////////////

    typedef enum logic [OP_W-1:0]
    {
        OP_INIT        = 3'd0,  // clear A, B, sum and display
        OP_LOAD_A      = 3'd1,
        OP_LOAD_B      = 3'd2,
        OP_ADD         = 3'd3,  // sum = A + B
        OP_SHOW_A      = 3'd4,
        OP_SHOW_B      = 3'd5,
        OP_SHOW_SUM_LO = 3'd6,  // tens and ones of the sum
        OP_SHOW_SUM_HI = 3'd7   // hundreds of the sum
    } bcdOp;

endpackage

/* bcdOperandStage.sv */
`timescale 1ns/1ps

module bcdOperandStage import bcdAdderPkg::*;
(
    input  logic                 CLK,
    input  logic                 rstN,
    input  logic                 cmdValid,
    input  bcdOp                 cmdOp,
    input  logic [OPERAND_W-1:0] cmdData,
    output logic                 s1Valid,
    output bcdOp                 s1Op,
    output logic [SUM_W-1:0]     s1Value
);

    // Operand and result registers
    logic [OPERAND_W-1:0] opA;
    logic [OPERAND_W-1:0] opB;
    logic [SUM_W-1:0]     sumReg;

    // Binary value picked for a show command
    logic [SUM_W-1:0]     showValue;

    //////////////////////////////////////////////////
    // Command execution
    //////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            opA    <= '0;
            opB    <= '0;
            sumReg <= '0;
        end
        else if (cmdValid)
        begin
            case (cmdOp)
                OP_INIT:
                begin
                    opA    <= '0;
                    opB    <= '0;
                    sumReg <= '0;
                end
                OP_LOAD_A: opA <= cmdData;
                OP_LOAD_B: opB <= cmdData;
                // Nine bits so 255 + 255 keeps its carry
                OP_ADD:    sumReg <= SUM_W'(opA) + SUM_W'(opB);
                default:   ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Value forwarded to conversion
    //////////////////////////////////////////////////

    // Sees registers as written by the previous command
    always_comb
    begin
        case (cmdOp)
            OP_SHOW_A:      showValue = SUM_W'(opA);
            OP_SHOW_B:      showValue = SUM_W'(opB);
            OP_SHOW_SUM_LO: showValue = sumReg;
            OP_SHOW_SUM_HI: showValue = sumReg;
            default:        showValue = '0;
        endcase
    end

    // Valid is control, opcode and value are payload
    always_ff @(posedge CLK)
    begin
        if (!rstN)
            s1Valid <= 1'b0;
        else
            s1Valid <= cmdValid;
    end

    always_ff @(posedge CLK)
    begin
        s1Op    <= cmdOp;
        s1Value <= showValue;
    end

    // Caller must present a known opcode with every command
    assert property (@(posedge CLK) disable iff (!rstN)
        cmdValid |-> !$isunknown(cmdOp));

endmodule

/* bcdConvertStage.sv */
`timescale 1ns/1ps

module bcdConvertStage import bcdAdderPkg::*;
(
    input  logic               CLK,
    input  logic               rstN,
    input  logic               s1Valid,
    input  bcdOp               s1Op,
    input  logic [SUM_W-1:0]   s1Value,
    output logic               s2Valid,
    output bcdOp               s2Op,
    output logic [DIGIT_W-1:0] s2Hundreds,
    output logic [DIGIT_W-1:0] s2Tens,
    output logic [DIGIT_W-1:0] s2Ones
);

    // Hundreds in the top nibble, ones in the bottom
    logic [DISPLAY_W-1:0] bcdWork;

    //////////////////////////////////////////////////
    // Double dabble
    //////////////////////////////////////////////////

    // One pass per input bit, MSB first
    always_comb
    begin
        bcdWork = '0;
        for (int i = SUM_W - 1; i >= 0; i--)
        begin
            // Add three to any digit of five or more before the shift
            for (int d = 0; d < NUM_DIGITS; d++)
            begin
                if (bcdWork[d*DIGIT_W +: DIGIT_W] > DIGIT_W'(4))
                    bcdWork[d*DIGIT_W +: DIGIT_W] =
                        bcdWork[d*DIGIT_W +: DIGIT_W] + DIGIT_W'(3);
            end
            // Shift next binary bit into the ones digit
            bcdWork = {bcdWork[DISPLAY_W-2:0], s1Value[i]};
        end
    end

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (!rstN)
            s2Valid <= 1'b0;
        else
            s2Valid <= s1Valid;
    end

    // Digits travel with their opcode
    always_ff @(posedge CLK)
    begin
        s2Op       <= s1Op;
        s2Hundreds <= bcdWork[2*DIGIT_W +: DIGIT_W];
        s2Tens     <= bcdWork[DIGIT_W +: DIGIT_W];
        s2Ones     <= bcdWork[0 +: DIGIT_W];
    end

    // Every digit handed on is a decimal digit
    assert property (@(posedge CLK) disable iff (!rstN)
        s2Valid |-> (s2Hundreds <= DIGIT_W'(DIGIT_MAX)) &&
                    (s2Tens <= DIGIT_W'(DIGIT_MAX)) &&
                    (s2Ones <= DIGIT_W'(DIGIT_MAX)));

    // Nine-bit sum tops out at 510
    assert property (@(posedge CLK) disable iff (!rstN)
        s2Valid |-> s2Hundreds <= DIGIT_W'(HUNDREDS_MAX));

endmodule

/* bcdDisplayStage.sv */
`timescale 1ns/1ps

module bcdDisplayStage import bcdAdderPkg::*;
(
    input  logic                 CLK,
    input  logic                 rstN,
    input  logic                 s2Valid,
    input  bcdOp                 s2Op,
    input  logic [DIGIT_W-1:0]   s2Hundreds,
    input  logic [DIGIT_W-1:0]   s2Tens,
    input  logic [DIGIT_W-1:0]   s2Ones,
    output logic [DISPLAY_W-1:0] display,
    output logic                 ack,
    output bcdOp                 ackOp
);

    //////////////////////////////////////////////////
    // Display word and acknowledge
    //////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            display <= '0;
            ack     <= 1'b0;
        end
        else
        begin
            // One ack per command leaving stage 2
            ack <= s2Valid;
            if (s2Valid)
            begin
                case (s2Op)
                    OP_INIT:        display <= '0;
                    OP_SHOW_A,
                    OP_SHOW_B:      display <= {s2Hundreds, s2Tens, s2Ones};
                    // Low two digits, top digit blanked to zero
                    OP_SHOW_SUM_LO: display <= {{DIGIT_W{1'b0}}, s2Tens, s2Ones};
                    // Hundreds moved down to the ones position
                    OP_SHOW_SUM_HI: display <= {{2*DIGIT_W{1'b0}}, s2Hundreds};
                    // Loads and add keep the last shown value
                    default:        ;
                endcase
            end
        end
    end

    // Echo of the opcode, meaningful only with ack
    always_ff @(posedge CLK)
    begin
        ackOp <= s2Op;
    end

    // Display moves only together with an acknowledge
    assert property (@(posedge CLK) disable iff (!rstN)
        (display != $past(display)) |-> ack);

endmodule

/* bcdAdder.sv */
`timescale 1ns/1ps

module bcdAdder import bcdAdderPkg::*;
(
    input  logic                 CLK,
    input  logic                 rstN,
    input  logic                 cmdValid,
    input  bcdOp                 cmdOp,
    input  logic [OPERAND_W-1:0] cmdData,
    output logic [DISPLAY_W-1:0] display,
    output logic                 ack,
    output bcdOp                 ackOp
);

    // Stage 1 to stage 2
    logic               s1Valid;
    bcdOp               s1Op;
    logic [SUM_W-1:0]   s1Value;

    // Stage 2 to stage 3
    logic               s2Valid;
    bcdOp               s2Op;
    logic [DIGIT_W-1:0] s2Hundreds;
    logic [DIGIT_W-1:0] s2Tens;
    logic [DIGIT_W-1:0] s2Ones;

    //////////////////////////////////////////////////
    // Pipeline
    //////////////////////////////////////////////////

    // Execute command, pick binary value
    bcdOperandStage i_bcdOperandStage
    (
        .CLK      (CLK),
        .rstN     (rstN),
        .cmdValid (cmdValid),
        .cmdOp    (cmdOp),
        .cmdData  (cmdData),
        .s1Valid  (s1Valid),
        .s1Op     (s1Op),
        .s1Value  (s1Value)
    );

    // Binary to three BCD digits
    bcdConvertStage i_bcdConvertStage
    (
        .CLK        (CLK),
        .rstN       (rstN),
        .s1Valid    (s1Valid),
        .s1Op       (s1Op),
        .s1Value    (s1Value),
        .s2Valid    (s2Valid),
        .s2Op       (s2Op),
        .s2Hundreds (s2Hundreds),
        .s2Tens     (s2Tens),
        .s2Ones     (s2Ones)
    );

    // Digit select and acknowledge
    bcdDisplayStage i_bcdDisplayStage
    (
        .CLK        (CLK),
        .rstN       (rstN),
        .s2Valid    (s2Valid),
        .s2Op       (s2Op),
        .s2Hundreds (s2Hundreds),
        .s2Tens     (s2Tens),
        .s2Ones     (s2Ones),
        .display    (display),
        .ack        (ack),
        .ackOp      (ackOp)
    );

endmodule

/* bcdAdderClock.sv */
`timescale 1ns/1ps

module bcdAdderClock
(
    output logic CLK
);

    // Half of the 8 ns period
    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

endmodule

/* bcdAdderTb.sv */
`timescale 1ns/1ps

module bcdAdderTb import bcdAdderPkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int RANDOM_GROUPS = 24;
    localparam int TIMEOUT_MARGIN = 20;

    logic                 CLK;
    logic                 rstN;
    logic                 cmdValid;
    bcdOp                 cmdOp;
    logic [OPERAND_W-1:0] cmdData;
    logic [DISPLAY_W-1:0] display;
    logic                 ack;
    bcdOp                 ackOp;

    // Stimulus table, one row per command
    bcdOp                 rowOp[$];
    logic [OPERAND_W-1:0] rowData[$];
    bcdOp                 rowExpOp[$];
    logic [DISPLAY_W-1:0] rowExpDisp[$];

    // Expected results of commands in flight
    bcdOp                 expOpQ[$];
    logic [DISPLAY_W-1:0] expDispQ[$];
    bcdOp                 expOpNow;
    logic [DISPLAY_W-1:0] expDispNow;

    // Cycle at which each ack is due
    int                   expCycleQ[$];
    int                   expCycleNow;

    // Reference model of the operand registers
    int                   modelA = 0;
    int                   modelB = 0;
    int                   modelSum = 0;
    logic [DISPLAY_W-1:0] modelDisplay = '0;

    logic [31:0]          lfsrState = 32'hb2fa_d523;
    int                   cycleCount = 0;
    int                   timeoutLimit = 0;
    int                   drainCycles = 0;
    logic [OPERAND_W-1:0] randA;
    logic [OPERAND_W-1:0] randB;

    bcdAdderClock i_bcdAdderClock (.CLK(CLK));

    bcdAdder i_bcdAdder
    (
        .CLK      (CLK),
        .rstN     (rstN),
        .cmdValid (cmdValid),
        .cmdOp    (cmdOp),
        .cmdData  (cmdData),
        .display  (display),
        .ack      (ack),
        .ackOp    (ackOp)
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeRandomByte(output logic [OPERAND_W-1:0] b);
        b = '0;
        for (int k = 0; k < OPERAND_W; k++)
        begin
            lfsrState = lfsrStep(lfsrState);
            b = {b[OPERAND_W-2:0], lfsrState[0]};
        end
    endtask

    // Decimal split by division
    function automatic logic [DISPLAY_W-1:0] toDigits(input int value);
        int hundreds;
        int tens;
        int ones;
        hundreds = value / 100;
        tens = (value / 10) % 10;
        ones = value % 10;
        return {hundreds[DIGIT_W-1:0], tens[DIGIT_W-1:0], ones[DIGIT_W-1:0]};
    endfunction

    // Steps the model and appends one table row
    task automatic addRow(input bcdOp op, input logic [OPERAND_W-1:0] data);
        logic [DISPLAY_W-1:0] digits;
        digits = toDigits(modelSum);
        case (op)
            OP_INIT:
            begin
                modelA = 0;
                modelB = 0;
                modelSum = 0;
                modelDisplay = '0;
            end
            OP_LOAD_A:      modelA = int'(data);
            OP_LOAD_B:      modelB = int'(data);
            OP_ADD:         modelSum = modelA + modelB;
            OP_SHOW_A:      modelDisplay = toDigits(modelA);
            OP_SHOW_B:      modelDisplay = toDigits(modelB);
            OP_SHOW_SUM_LO: modelDisplay = {{DIGIT_W{1'b0}}, digits[2*DIGIT_W-1:0]};
            OP_SHOW_SUM_HI: modelDisplay = {{2*DIGIT_W{1'b0}}, digits[3*DIGIT_W-1:2*DIGIT_W]};
            default:        ;
        endcase
        rowOp.push_back(op);
        rowData.push_back(data);
        rowExpOp.push_back(op);
        rowExpDisp.push_back(modelDisplay);
    endtask

    //////////////////////////////////////////////////
    // Monitor and timeout
    //////////////////////////////////////////////////

    // Outputs settle after the rising edge, sampled on the falling one
    always @(negedge CLK)
    begin
        if (ack === 1'b1)
        begin
            if (expOpQ.size() == 0)
            begin
                $display("Acknowledge seen with no command outstanding");
                $display("TEST FAILED");
                $fatal(1, "Unexpected acknowledge");
            end
            else
            begin
                expOpNow = expOpQ.pop_front();
                expDispNow = expDispQ.pop_front();
                expCycleNow = expCycleQ.pop_front();
                checkValue("ack cycle", 32'(cycleCount), 32'(expCycleNow));
                checkValue("ackOp", 32'(ackOp), 32'(expOpNow));
                checkValue("display", 32'(display), 32'(expDispNow));
            end
        end
    end

    always @(posedge CLK)
    begin
        cycleCount++;
        if (timeoutLimit > 0 && cycleCount > timeoutLimit)
        begin
            $display("Run did not finish within %0d cycles", timeoutLimit);
            $display("TEST FAILED");
            $fatal(1, "Timeout");
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial
    begin
        rstN = 1'b0;
        cmdValid = 1'b0;
        cmdOp = OP_INIT;
        cmdData = '0;

        // Operands, show right after load, 255 + 7
        addRow(OP_LOAD_A, 8'd255);
        addRow(OP_SHOW_A, 8'h00);
        addRow(OP_LOAD_B, 8'd7);
        addRow(OP_SHOW_B, 8'h5a);
        addRow(OP_SHOW_A, 8'h00);
        addRow(OP_ADD, 8'h00);
        addRow(OP_SHOW_SUM_LO, 8'h00);
        addRow(OP_SHOW_SUM_HI, 8'h00);
        // Largest sum 255 + 255
        addRow(OP_LOAD_B, 8'd255);
        addRow(OP_ADD, 8'h00);
        addRow(OP_SHOW_SUM_LO, 8'h00);
        addRow(OP_SHOW_SUM_HI, 8'h00);
        // Zero sum
        addRow(OP_LOAD_A, 8'd0);
        addRow(OP_LOAD_B, 8'd0);
        addRow(OP_ADD, 8'h00);
        addRow(OP_SHOW_SUM_LO, 8'h00);
        addRow(OP_SHOW_SUM_HI, 8'h00);
        // Carry into hundreds, later load must not touch the sum
        addRow(OP_LOAD_A, 8'd99);
        addRow(OP_LOAD_B, 8'd1);
        addRow(OP_SHOW_B, 8'h00);
        addRow(OP_ADD, 8'h00);
        addRow(OP_LOAD_A, 8'd3);
        addRow(OP_SHOW_SUM_LO, 8'h00);
        addRow(OP_SHOW_SUM_HI, 8'h00);
        // Init after loads clears everything
        addRow(OP_INIT, 8'hff);
        addRow(OP_SHOW_A, 8'h00);
        addRow(OP_SHOW_B, 8'h00);
        addRow(OP_SHOW_SUM_HI, 8'h00);

        // Random sums, show order picked by one LFSR bit
        for (int g = 0; g < RANDOM_GROUPS; g++)
        begin
            takeRandomByte(randA);
            takeRandomByte(randB);
            addRow(OP_LOAD_A, randA);
            addRow(OP_LOAD_B, randB);
            addRow(OP_ADD, 8'h00);
            lfsrState = lfsrStep(lfsrState);
            addRow(lfsrState[0] ? OP_SHOW_SUM_HI : OP_SHOW_SUM_LO, 8'h00);
            addRow(lfsrState[0] ? OP_SHOW_SUM_LO : OP_SHOW_SUM_HI, 8'h00);
        end
        timeoutLimit = RESET_CYCLES + rowOp.size() + PIPE_DEPTH + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(posedge CLK);
        #1 rstN = 1'b1;
        @(negedge CLK);
        checkValue("display", 32'(display), 32'(0));

        // Back to back, one row per cycle
        for (int i = 0; i < rowOp.size(); i++)
        begin
            @(posedge CLK);
            #1;
            cmdValid = 1'b1;
            cmdOp = rowOp[i];
            cmdData = rowData[i];
            expOpQ.push_back(rowExpOp[i]);
            expDispQ.push_back(rowExpDisp[i]);
            // Taken at the next edge, ack after PIPE_DEPTH edges in all
            expCycleQ.push_back(cycleCount + PIPE_DEPTH);
        end
        @(posedge CLK);
        #1 cmdValid = 1'b0;

        // Drain the pipeline, then give stray acks a chance to show
        while (expOpQ.size() > 0 && drainCycles < PIPE_DEPTH + 2)
        begin
            @(posedge CLK);
            drainCycles++;
        end
        repeat (2) @(posedge CLK);

        if (expOpQ.size() != 0)
        begin
            $display("%0d commands never acknowledged", expOpQ.size());
            $display("TEST FAILED");
            $fatal(1, "Missing acknowledge");
        end
        else
        begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* bcdAdder.f */
bcdAdderPkg.sv
bcdOperandStage.sv
bcdConvertStage.sv
bcdDisplayStage.sv
bcdAdder.sv
bcdAdderClock.sv
bcdAdderTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = bcdAdderTb
FILELIST = bcdAdder.f
BUILDDIR = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP)

clean:
	rm -rf $(BUILDDIR)
